// ==== Makefile ====
# Verilator build and run of the channelizer testbench
VERILATOR ?= verilator
TOP ?= tb_channelizer
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/chan_ctrl.sv ====
// configuration registers beside the datapath: latches the transform size,
// decodes its exponent and stretches the internal reset after reset or a size change
`timescale 1ns/1ps

module chan_ctrl (
    input  logic clk,
    input  logic sync_reset,
    input  chan_pkg::fft_size_t fft_size_i,
    output chan_pkg::nfft_t nfft_o,
    output logic int_reset_o
);
    import chan_pkg::*;

    fft_size_t fft_size_q;
    logic [4:0] reset_cnt;
    logic [4:0] next_cnt;
    logic size_change;

    // powers of two from 8 to 1024 map to their exponent, anything else to the max
    function automatic nfft_t decode_nfft(input fft_size_t size);
        nfft_t n;
        n = nfft_t'(MAX_NFFT);
        for (int i = MIN_NFFT; i < MAX_NFFT; i++) begin
            if (size == fft_size_t'(1 << i)) begin
                n = nfft_t'(i);
            end
        end
        return n;
    endfunction

    // zero on the size input means keep the current setting
    assign size_change = (fft_size_i != '0) && (fft_size_i != fft_size_q);

    always_comb begin
        if (size_change) begin
            next_cnt = 5'(RESET_HIGH_CNT);
        end else if (reset_cnt != '0) begin
            next_cnt = reset_cnt - 1'b1;
        end else begin
            next_cnt = reset_cnt;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            fft_size_q <= fft_size_t'(DEFAULT_FFT_SIZE);
            nfft_o <= decode_nfft(fft_size_t'(DEFAULT_FFT_SIZE));
            reset_cnt <= 5'(RESET_START_CNT);
            int_reset_o <= 1'b1;
        end else begin
            reset_cnt <= next_cnt;
            // registered so the datapath sees a clean reset edge
            int_reset_o <= (next_cnt != '0);
            if (size_change) begin
                fft_size_q <= fft_size_i;
                nfft_o <= decode_nfft(fft_size_i);
            end
        end
    end

    // datapath must be held in reset for the full stretch after a size change
    assert property (@(posedge clk) disable iff (sync_reset)
        $past(size_change, RESET_HIGH_CNT) |-> int_reset_o)
        else $error("int_reset dropped too early after size change");

endmodule

// ==== hdl/chan_pkg.sv ====
// shared widths, size limits and stream beat types for the channelizer front end
// compiled before every other source; modules pull it in with a wildcard import
package chan_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int MAX_NFFT = 11;
    localparam int MIN_NFFT = 3;
    localparam int RESET_HIGH_CNT = 8;
    localparam int RESET_START_CNT = 31;
    localparam int DEFAULT_FFT_SIZE = 128;

    typedef logic [DATA_WIDTH-1:0] sample_t;
    typedef logic [MAX_NFFT-1:0] phase_t;
    typedef logic [4:0] nfft_t;
    typedef logic [MAX_NFFT:0] fft_size_t;
    typedef logic [15:0] payload_len_t;
    typedef logic [23:0] frame_idx_t;

    // sample plus its position in the frame
    typedef struct packed {
        sample_t data;
        phase_t phase;
        logic last;
    } chan_beat_t;

    // output word, tagged with frame number and end of payload
    typedef struct packed {
        sample_t data;
        frame_idx_t frame;
        logic last;
    } out_beat_t;

endpackage

// ==== hdl/channelizer_top.sv ====
// channelizer front end: control block plus input, circular and framing stages
`timescale 1ns/1ps

module channelizer_top (
    input  logic clk,
    input  logic sync_reset,
    input  logic s_valid_i,
    input  chan_pkg::sample_t s_data_i,
    output logic s_ready_o,
    input  chan_pkg::fft_size_t fft_size_i,
    input  chan_pkg::payload_len_t payload_length_i,
    output logic busy_o,
    output logic m_valid_o,
    output chan_pkg::sample_t m_data_o,
    output chan_pkg::frame_idx_t m_frame_o,
    output logic m_last_o,
    input  logic m_ready_i
);
    import chan_pkg::*;

    nfft_t nfft;
    logic int_reset;
    logic buf_valid;
    logic buf_ready;
    chan_beat_t buf_beat;
    logic circ_valid;
    logic circ_ready;
    chan_beat_t circ_beat;
    frame_idx_t circ_frame;
    out_beat_t out_beat;

    assign busy_o = int_reset;
    assign m_data_o = out_beat.data;
    assign m_frame_o = out_beat.frame;
    assign m_last_o = out_beat.last;

    chan_ctrl u_ctrl (
        .clk(clk), .sync_reset(sync_reset), .fft_size_i(fft_size_i),
        .nfft_o(nfft), .int_reset_o(int_reset)
    );

    input_buffer u_input_buffer (
        .clk(clk), .int_reset_i(int_reset), .nfft_i(nfft),
        .s_valid_i(s_valid_i), .s_data_i(s_data_i), .s_ready_o(s_ready_o),
        .m_valid_o(buf_valid), .m_beat_o(buf_beat), .m_ready_i(buf_ready)
    );

    circ_buffer u_circ_buffer (
        .clk(clk), .int_reset_i(int_reset), .nfft_i(nfft),
        .s_valid_i(buf_valid), .s_beat_i(buf_beat), .s_ready_o(buf_ready),
        .m_valid_o(circ_valid), .m_beat_o(circ_beat), .m_frame_o(circ_frame),
        .m_ready_i(circ_ready)
    );

    payload_framer u_framer (
        .clk(clk), .int_reset_i(int_reset), .payload_length_i(payload_length_i),
        .s_valid_i(circ_valid), .s_beat_i(circ_beat), .s_frame_i(circ_frame),
        .s_ready_o(circ_ready), .m_valid_o(m_valid_o), .m_beat_o(out_beat),
        .m_ready_i(m_ready_i)
    );

endmodule

// ==== hdl/circ_buffer.sv ====
// ping-pong frame store: odd frames are read rotated by half a frame,
// even frames straight; each output beat carries its frame number
`timescale 1ns/1ps

module circ_buffer (
    input  logic clk,
    input  logic int_reset_i,
    input  chan_pkg::nfft_t nfft_i,
    input  logic s_valid_i,
    input  chan_pkg::chan_beat_t s_beat_i,
    output logic s_ready_o,
    output logic m_valid_o,
    output chan_pkg::chan_beat_t m_beat_o,
    output chan_pkg::frame_idx_t m_frame_o,
    input  logic m_ready_i
);
    import chan_pkg::*;

    // bank select is the top address bit
    sample_t bank_mem [2**(MAX_NFFT+1)];

    logic wr_bank;
    logic rd_bank;
    logic [1:0] bank_full;
    phase_t wr_off;
    phase_t rd_off;
    phase_t rd_addr;
    phase_t phase_mask;
    phase_t half;
    frame_idx_t frame_cnt;
    fft_size_t m_size;
    logic wr_en;
    logic rd_en;
    logic rd_last;

    assign m_size = fft_size_t'(1) << nfft_i;
    assign phase_mask = phase_t'(m_size - 1'b1);
    assign half = m_size[MAX_NFFT:1];

    assign s_ready_o = !bank_full[wr_bank];
    assign wr_en = s_valid_i && s_ready_o;
    assign rd_en = bank_full[rd_bank] && (!m_valid_o || m_ready_i);
    assign rd_last = rd_off == phase_mask;

    // odd frames start half a frame in and wrap
    assign rd_addr = frame_cnt[0] ? ((rd_off + half) & phase_mask) : rd_off;

    always_ff @(posedge clk or posedge int_reset_i) begin
        if (int_reset_i) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            bank_full <= '0;
            wr_off <= '0;
            rd_off <= '0;
            frame_cnt <= '0;
            m_valid_o <= 1'b0;
        end else begin
            if (wr_en) begin
                if (s_beat_i.last) begin
                    wr_off <= '0;
                    bank_full[wr_bank] <= 1'b1;
                    wr_bank <= ~wr_bank;
                end else begin
                    wr_off <= wr_off + 1'b1;
                end
            end
            if (rd_en) begin
                m_valid_o <= 1'b1;
                if (rd_last) begin
                    rd_off <= '0;
                    bank_full[rd_bank] <= 1'b0;
                    rd_bank <= ~rd_bank;
                    frame_cnt <= frame_cnt + 1'b1;
                end else begin
                    rd_off <= rd_off + 1'b1;
                end
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank_mem[{wr_bank, wr_off}] <= s_beat_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            m_beat_o <= '{data: bank_mem[{rd_bank, rd_addr}], phase: rd_off, last: rd_last};
            m_frame_o <= frame_cnt;
        end
    end

    // upstream phase must line up with the local fill position
    assert property (@(posedge clk) disable iff (int_reset_i)
        wr_en |-> (s_beat_i.phase == wr_off))
        else $error("incoming phase out of step with write address");

endmodule

// ==== hdl/input_buffer.sv ====
// overlapping frame buffer: emits frames of M samples that advance by M/2
// per frame, each sample tagged with its phase and end of frame
`timescale 1ns/1ps

module input_buffer (
    input  logic clk,
    input  logic int_reset_i,
    input  chan_pkg::nfft_t nfft_i,
    input  logic s_valid_i,
    input  chan_pkg::sample_t s_data_i,
    output logic s_ready_o,
    output logic m_valid_o,
    output chan_pkg::chan_beat_t m_beat_o,
    input  logic m_ready_i
);
    import chan_pkg::*;

    // two frames of the largest size
    sample_t ring [2**(MAX_NFFT+1)];

    logic [MAX_NFFT+1:0] wr_ptr;
    logic [MAX_NFFT+1:0] start_ptr;
    logic [MAX_NFFT+1:0] fill;
    logic [MAX_NFFT+1:0] half_step;
    logic [MAX_NFFT:0] rd_addr;
    phase_t rd_off;
    fft_size_t m_size;
    logic running;
    logic wr_en;
    logic frame_ok;
    logic rd_en;
    logic rd_last;

    assign m_size = fft_size_t'(1) << nfft_i;
    assign half_step = {2'b00, m_size[MAX_NFFT:1]};

    // samples held from the current frame start onward
    assign fill = wr_ptr - start_ptr;

    // top bit set means the ring is full of unread samples
    assign s_ready_o = running && !fill[MAX_NFFT+1];
    assign wr_en = s_valid_i && s_ready_o;

    // whole frame must be in before it goes out
    assign frame_ok = fill >= {1'b0, m_size};
    assign rd_en = frame_ok && (!m_valid_o || m_ready_i);
    assign rd_last = rd_off == phase_t'(m_size - 1'b1);
    assign rd_addr = start_ptr[MAX_NFFT:0] + {1'b0, rd_off};

    always_ff @(posedge clk or posedge int_reset_i) begin
        if (int_reset_i) begin
            wr_ptr <= '0;
            start_ptr <= '0;
            rd_off <= '0;
            running <= 1'b0;
            m_valid_o <= 1'b0;
        end else begin
            running <= 1'b1;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                m_valid_o <= 1'b1;
                if (rd_last) begin
                    rd_off <= '0;
                    // next frame overlaps this one by half
                    start_ptr <= start_ptr + half_step;
                end else begin
                    rd_off <= rd_off + 1'b1;
                end
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ring[wr_ptr[MAX_NFFT:0]] <= s_data_i;
        end
    end

    // read port feeds the output register directly
    always_ff @(posedge clk) begin
        if (rd_en) begin
            m_beat_o <= '{data: ring[rd_addr], phase: rd_off, last: rd_last};
        end
    end

    // never more unread samples than the ring can hold
    assert property (@(posedge clk) disable iff (int_reset_i)
        fill <= {1'b1, {(MAX_NFFT+1){1'b0}}})
        else $error("ring holds more than its depth of unread samples");

endmodule

// ==== hdl/payload_framer.sv ====
// output register stage: counts words and flags the last word of each payload
`timescale 1ns/1ps

module payload_framer (
    input  logic clk,
    input  logic int_reset_i,
    input  chan_pkg::payload_len_t payload_length_i,
    input  logic s_valid_i,
    input  chan_pkg::chan_beat_t s_beat_i,
    input  chan_pkg::frame_idx_t s_frame_i,
    output logic s_ready_o,
    output logic m_valid_o,
    output chan_pkg::out_beat_t m_beat_o,
    input  logic m_ready_i
);
    import chan_pkg::*;

    payload_len_t word_cnt;
    logic word_last;
    logic load;

    assign s_ready_o = !m_valid_o || m_ready_i;
    assign load = s_valid_i && s_ready_o;
    assign word_last = word_cnt == (payload_length_i - 1'b1);

    always_ff @(posedge clk or posedge int_reset_i) begin
        if (int_reset_i) begin
            word_cnt <= '0;
            m_valid_o <= 1'b0;
        end else begin
            if (load) begin
                m_valid_o <= 1'b1;
                word_cnt <= word_last ? '0 : word_cnt + 1'b1;
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_beat_o <= '{data: s_beat_i.data, frame: s_frame_i, last: word_last};
        end
    end

    // upstream keeps its beat steady until this stage takes it
    assert property (@(posedge clk) disable iff (int_reset_i)
        (s_valid_i && !s_ready_o) |=>
            (s_valid_i && $stable(s_beat_i) && $stable(s_frame_i)))
        else $error("input beat changed while stalled");

endmodule

// ==== sim/tb_channelizer.sv ====
// testbench for the channelizer front end: walks a table of sizes and payload
// lengths, streams counter samples and checks every output word against a model
`timescale 1ns/1ps

module tb_channelizer;
    import chan_pkg::*;

    // one test: size input, payload length, frames to check, size in effect
    typedef struct packed {
        fft_size_t fft_size;
        payload_len_t payload_len;
        logic [15:0] frames;
        fft_size_t exp_size;
        logic [15:0] stall_cycles;
    } test_row_t;

    logic clk;
    logic sync_reset;
    logic s_valid_i;
    sample_t s_data_i;
    logic s_ready_o;
    fft_size_t fft_size_i;
    payload_len_t payload_length_i;
    logic busy_o;
    logic m_valid_o;
    sample_t m_data_o;
    frame_idx_t m_frame_o;
    logic m_last_o;
    logic m_ready_i;

    test_row_t rows [5];
    logic [31:0] lcg_state;

    channelizer_top uut (
        .clk(clk), .sync_reset(sync_reset), .s_valid_i(s_valid_i), .s_data_i(s_data_i),
        .s_ready_o(s_ready_o), .fft_size_i(fft_size_i), .payload_length_i(payload_length_i),
        .busy_o(busy_o), .m_valid_o(m_valid_o), .m_data_o(m_data_o), .m_frame_o(m_frame_o),
        .m_last_o(m_last_o), .m_ready_i(m_ready_i)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy_o !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy_o !== level) begin
            stop_on_timeout(what);
        end
    endtask

    // streams samples and checks output words until all frames of the row are seen
    task automatic run_row(input test_row_t row);
        int m;
        int half;
        int k;
        int i;
        int sent;
        int received;
        int cycles;
        int limit;
        int total_words;
        int total_samples;
        logic in_fire;
        logic out_fire;
        logic ready_dropped;
        sample_t exp_data;
        m = int'(row.exp_size);
        half = m / 2;
        total_words = int'(row.frames) * m;
        total_samples = (int'(row.frames) + 1) * half;
        limit = int'(row.stall_cycles) + 8 * total_words + 2000;
        sent = 0;
        received = 0;
        cycles = 0;
        ready_dropped = 1'b0;
        while (received < total_words && cycles < limit) begin
            @(negedge clk);
            s_valid_i = sent < total_samples;
            s_data_i = sample_t'(sent);
            lcg_state = lcg_next(lcg_state);
            // roughly one stall in four, none accepted during the long stall
            m_ready_i = (cycles >= int'(row.stall_cycles)) && (lcg_state[31:30] != 2'b00);
            #1;
            in_fire = s_valid_i && s_ready_o;
            out_fire = m_valid_o && m_ready_i;
            if (s_valid_i && !s_ready_o && sent > 0) begin
                ready_dropped = 1'b1;
            end
            if (out_fire) begin
                k = received / m;
                i = received % m;
                // frame k starts at sample k*M/2, odd frames rotated by M/2
                exp_data = sample_t'(k * half + ((i + (k % 2) * half) % m));
                check_value("m_data_o", m_data_o, exp_data);
                check_value("m_frame_o", 32'(m_frame_o), 32'(k));
                check_value("m_last_o", 32'(m_last_o),
                            32'((received + 1) % int'(row.payload_len) == 0));
                received++;
            end
            @(posedge clk);
            if (in_fire) begin
                sent++;
            end
            cycles++;
        end
        if (received < total_words) begin
            stop_on_timeout("output words of a frame");
        end
        if (row.stall_cycles != 0) begin
            check_value("s_ready_o drop", 32'(ready_dropped), 32'd1);
        end
        @(negedge clk);
        s_valid_i = 1'b0;
        m_ready_i = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        sync_reset = 1'b1;
        s_valid_i = 1'b0;
        s_data_i = '0;
        fft_size_i = '0;
        payload_length_i = 16'd64;
        m_ready_i = 1'b1;
        lcg_state = 32'hcc45_e8ac;
        rows[0] = '{fft_size: 12'd0, payload_len: 16'd64, frames: 16'd4,
                    exp_size: 12'd128, stall_cycles: 16'd0};
        rows[1] = '{fft_size: 12'd8, payload_len: 16'd5, frames: 16'd12,
                    exp_size: 12'd8, stall_cycles: 16'd0};
        rows[2] = '{fft_size: 12'd16, payload_len: 16'd8, frames: 16'd10,
                    exp_size: 12'd16, stall_cycles: 16'd0};
        rows[3] = '{fft_size: 12'd64, payload_len: 16'd5, frames: 16'd6,
                    exp_size: 12'd64, stall_cycles: 16'd0};
        // long stall fills the input ring
        rows[4] = '{fft_size: 12'd8, payload_len: 16'd5, frames: 16'd1100,
                    exp_size: 12'd8, stall_cycles: 16'd4300};
        repeat (8) @(posedge clk);
        @(negedge clk);
        sync_reset = 1'b0;
        check_value("busy_o", 32'(busy_o), 32'd1);
        for (int r = 0; r < $size(rows); r++) begin
            @(negedge clk);
            fft_size_i = rows[r].fft_size;
            payload_length_i = rows[r].payload_len;
            wait_busy(1'b1, 20, "busy_o to rise");
            wait_busy(1'b0, 100, "busy_o to fall");
            run_row(rows[r]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/chan_pkg.sv
hdl/chan_ctrl.sv
hdl/input_buffer.sv
hdl/circ_buffer.sv
hdl/payload_framer.sv
hdl/channelizer_top.sv
sim/tb_channelizer.sv
